// File: design/isa_pkg.sv
package isa_pkg;

    // instruction field widths
    localparam int op_w  = 4;
    localparam int imm_w = 16;

    typedef enum logic [op_w-1:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_MOVI  = 4'h5,
        OP_CMP   = 4'h6,
        OP_SETLR = 4'h7,
        OP_GETLR = 4'h8,
        OP_GETFL = 4'h9
    } opcode_e;

    // bit 1 is negative, bit 0 is zero
    typedef struct packed {
        logic neg;
        logic zero;
    } fl_t;

    function automatic logic op_writes_rd(input opcode_e op);
        return !(op inside {OP_CMP, OP_SETLR});
    endfunction

    function automatic logic op_writes_fl(input opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP};
    endfunction

    function automatic logic op_writes_lr(input opcode_e op);
        return op == OP_SETLR;
    endfunction

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

    // general register file geometry
    localparam int reg_idx_w = 5;
    localparam int reg_count = 1 << reg_idx_w;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // source of a register operand, newest stage wins
    typedef enum logic [1:0] {
        FWD_RF   = 2'd0,
        FWD_MEWB = 2'd1,
        FWD_EXME = 2'd2
    } fwd_sel_e;

    // source of FL or LR
    typedef enum logic [1:0] {
        STATE_ARCH = 2'd0,
        STATE_MEWB = 2'd1,
        STATE_EXME = 2'd2
    } fwd_state_e;

endpackage

// File: design/stage_if.sv
`timescale 1ns/1ps

// decoded instruction with its register-file operands
interface issue_if #(
    parameter int data_w = 32
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic              valid;
    opcode_e           op;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    reg_idx_t          rs2;
    logic [imm_w-1:0]  imm;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic              reg_wr;
    logic              fl_wr;
    logic              lr_wr;

    modport producer (output valid, op, rd, rs1, rs2, imm, a, b, reg_wr, fl_wr, lr_wr);
    modport consumer (input valid, op, rd, rs1, rs2, imm, a, b, reg_wr, fl_wr, lr_wr);

endinterface

// result of one pipeline stage, FL and LR are the values after the instruction
interface result_if #(
    parameter int data_w = 32
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic              valid;
    reg_idx_t          rd;
    logic              reg_wr;
    logic              fl_wr;
    logic              lr_wr;
    logic [data_w-1:0] data;
    fl_t               fl;
    logic [data_w-1:0] lr;

    modport source (output valid, rd, reg_wr, fl_wr, lr_wr, data, fl, lr);
    modport sink   (input valid, rd, reg_wr, fl_wr, lr_wr, data, fl, lr);
    modport snoop  (input valid, rd, reg_wr, fl_wr, lr_wr, data, fl, lr);

endinterface

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int data_w = 32
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      advance,
    input  logic                      instr_valid,
    input  isa_pkg::opcode_e          instr_op,
    input  pipe_pkg::reg_idx_t        instr_rd,
    input  pipe_pkg::reg_idx_t        instr_rs1,
    input  pipe_pkg::reg_idx_t        instr_rs2,
    input  logic [isa_pkg::imm_w-1:0] instr_imm,
    output logic                      instr_ready,
    output pipe_pkg::reg_idx_t        rf_raddr1,
    output pipe_pkg::reg_idx_t        rf_raddr2,
    input  logic [data_w-1:0]         rf_rdata1,
    input  logic [data_w-1:0]         rf_rdata2,
    issue_if.producer                 de_ex
);
    import isa_pkg::*;

    logic take;

    // the pipe moves as a whole, so decode accepts whenever it advances
    assign instr_ready = advance;
    assign take        = instr_valid && advance;

    // register file is read during decode, writes from commit show through
    assign rf_raddr1 = instr_rs1;
    assign rf_raddr2 = instr_rs2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_ex.valid  <= 1'b0;
            de_ex.reg_wr <= 1'b0;
            de_ex.fl_wr  <= 1'b0;
            de_ex.lr_wr  <= 1'b0;
        end else if (advance) begin
            // a bubble carries no write flags
            de_ex.valid  <= take;
            de_ex.reg_wr <= take && op_writes_rd(instr_op);
            de_ex.fl_wr  <= take && op_writes_fl(instr_op);
            de_ex.lr_wr  <= take && op_writes_lr(instr_op);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            de_ex.op  <= instr_op;
            de_ex.rd  <= instr_rd;
            de_ex.rs1 <= instr_rs1;
            de_ex.rs2 <= instr_rs2;
            de_ex.imm <= instr_imm;
            de_ex.a   <= rf_rdata1;
            de_ex.b   <= rf_rdata2;
        end
    end

endmodule

// File: design/forwarding.sv
`timescale 1ns/1ps

module forwarding (
    issue_if.consumer             de_ex,
    result_if.snoop               exme,
    result_if.snoop               mewb,
    output pipe_pkg::fwd_sel_e    fwd1_sel,
    output pipe_pkg::fwd_sel_e    fwd2_sel,
    output pipe_pkg::fwd_state_e  fl_sel,
    output pipe_pkg::fwd_state_e  lr_sel
);
    import pipe_pkg::*;

    // ExMe holds the younger result, so it is checked first
    function automatic fwd_sel_e reg_src(input reg_idx_t rs);
        if (exme.valid && exme.reg_wr && (exme.rd != '0) && (exme.rd == rs)) begin
            return FWD_EXME;
        end
        if (mewb.valid && mewb.reg_wr && (mewb.rd != '0) && (mewb.rd == rs)) begin
            return FWD_MEWB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        fwd1_sel = reg_src(de_ex.rs1);
        fwd2_sel = reg_src(de_ex.rs2);
    end

    // FL and LR are decided by the write enables alone
    always_comb begin
        if (exme.valid && exme.fl_wr) begin
            fl_sel = STATE_EXME;
        end else if (mewb.valid && mewb.fl_wr) begin
            fl_sel = STATE_MEWB;
        end else begin
            fl_sel = STATE_ARCH;
        end
    end

    always_comb begin
        if (exme.valid && exme.lr_wr) begin
            lr_sel = STATE_EXME;
        end else if (mewb.valid && mewb.lr_wr) begin
            lr_sel = STATE_MEWB;
        end else begin
            lr_sel = STATE_ARCH;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              advance,
    issue_if.consumer         de_ex,
    result_if.snoop           mewb,
    input  isa_pkg::fl_t      arch_fl,
    input  logic [data_w-1:0] arch_lr,
    result_if.source          exme
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_e          fwd1_sel;
    fwd_sel_e          fwd2_sel;
    fwd_state_e        fl_sel;
    fwd_state_e        lr_sel;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_res;
    logic [data_w-1:0] cur_lr;
    logic [data_w-1:0] new_lr;
    fl_t               cur_fl;
    fl_t               new_fl;

    // ExMe register lives here so the forwarding unit can snoop it
    result_if #(.data_w(data_w)) exme_q ();

    forwarding u_forwarding (
        .de_ex    (de_ex),
        .exme     (exme_q),
        .mewb     (mewb),
        .fwd1_sel (fwd1_sel),
        .fwd2_sel (fwd2_sel),
        .fl_sel   (fl_sel),
        .lr_sel   (lr_sel)
    );

    function automatic logic [data_w-1:0] operand(input fwd_sel_e sel, input logic [data_w-1:0] rf_val);
        case (sel)
            FWD_EXME: return exme_q.data;
            FWD_MEWB: return mewb.data;
            default:  return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a   = operand(fwd1_sel, de_ex.a);
        op_b   = operand(fwd2_sel, de_ex.b);
        cur_fl = (fl_sel == STATE_EXME) ? exme_q.fl : (fl_sel == STATE_MEWB) ? mewb.fl : arch_fl;
        cur_lr = (lr_sel == STATE_EXME) ? exme_q.lr : (lr_sel == STATE_MEWB) ? mewb.lr : arch_lr;
        case (de_ex.op)
            OP_ADD:          alu_res = op_a + op_b;
            OP_SUB, OP_CMP:  alu_res = op_a - op_b;
            OP_AND:          alu_res = op_a & op_b;
            OP_OR:           alu_res = op_a | op_b;
            OP_XOR:          alu_res = op_a ^ op_b;
            OP_MOVI:         alu_res = {{(data_w-imm_w){1'b0}}, de_ex.imm};
            OP_SETLR:        alu_res = op_a;
            OP_GETLR:        alu_res = cur_lr;
            OP_GETFL:        alu_res = {{(data_w-2){1'b0}}, cur_fl};
            default:         alu_res = '0;
        endcase
        // stage carries the resolved FL and LR, written or passed along
        new_fl.neg  = de_ex.fl_wr ? alu_res[data_w-1] : cur_fl.neg;
        new_fl.zero = de_ex.fl_wr ? (alu_res == '0) : cur_fl.zero;
        new_lr      = de_ex.lr_wr ? op_a : cur_lr;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exme_q.valid  <= 1'b0;
            exme_q.reg_wr <= 1'b0;
            exme_q.fl_wr  <= 1'b0;
            exme_q.lr_wr  <= 1'b0;
        end else if (advance) begin
            exme_q.valid  <= de_ex.valid;
            exme_q.reg_wr <= de_ex.reg_wr;
            exme_q.fl_wr  <= de_ex.fl_wr;
            exme_q.lr_wr  <= de_ex.lr_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            exme_q.rd   <= de_ex.rd;
            exme_q.data <= alu_res;
            exme_q.fl   <= new_fl;
            exme_q.lr   <= new_lr;
        end
    end

    assign exme.valid  = exme_q.valid;
    assign exme.rd     = exme_q.rd;
    assign exme.reg_wr = exme_q.reg_wr;
    assign exme.fl_wr  = exme_q.fl_wr;
    assign exme.lr_wr  = exme_q.lr_wr;
    assign exme.data   = exme_q.data;
    assign exme.fl     = exme_q.fl;
    assign exme.lr     = exme_q.lr;

endmodule

// File: design/commit_stage.sv
`timescale 1ns/1ps

module commit_stage #(
    parameter int data_w = 32
) (
    input  logic               clk,
    input  logic               arst_n,
    result_if.sink             exme,
    result_if.source           mewb,
    input  pipe_pkg::reg_idx_t rf_raddr1,
    input  pipe_pkg::reg_idx_t rf_raddr2,
    output logic [data_w-1:0]  rf_rdata1,
    output logic [data_w-1:0]  rf_rdata2,
    output isa_pkg::fl_t       arch_fl,
    output logic [data_w-1:0]  arch_lr,
    output logic               advance,
    output logic               res_valid,
    input  logic               res_ready,
    output pipe_pkg::reg_idx_t res_rd,
    output logic [data_w-1:0]  res_data,
    output isa_pkg::fl_t       res_fl,
    output logic [data_w-1:0]  res_lr
);
    import pipe_pkg::*;

    logic [data_w-1:0] rf [reg_count];
    logic              commit;
    logic              rf_we;

    // only a held result blocks the pipe
    assign advance = !(mewb.valid && !res_ready);
    assign commit  = mewb.valid && res_ready;
    assign rf_we   = commit && mewb.reg_wr && (mewb.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mewb.valid  <= 1'b0;
            mewb.reg_wr <= 1'b0;
            mewb.fl_wr  <= 1'b0;
            mewb.lr_wr  <= 1'b0;
        end else if (advance) begin
            mewb.valid  <= exme.valid;
            mewb.reg_wr <= exme.reg_wr;
            mewb.fl_wr  <= exme.fl_wr;
            mewb.lr_wr  <= exme.lr_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mewb.rd   <= exme.rd;
            mewb.data <= exme.data;
            mewb.fl   <= exme.fl;
            mewb.lr   <= exme.lr;
        end
    end

    // architectural state, register 0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                rf[i] <= '0;
            end
            arch_fl <= '0;
            arch_lr <= '0;
        end else begin
            if (rf_we) rf[mewb.rd] <= mewb.data;
            if (commit && mewb.fl_wr) arch_fl <= mewb.fl;
            if (commit && mewb.lr_wr) arch_lr <= mewb.lr;
        end
    end

    // write-first read so decode sees the value committing this cycle
    function automatic logic [data_w-1:0] rf_read(input reg_idx_t addr);
        if (addr == '0) return '0;
        if (rf_we && (mewb.rd == addr)) return mewb.data;
        return rf[addr];
    endfunction

    always_comb begin
        rf_rdata1 = rf_read(rf_raddr1);
        rf_rdata2 = rf_read(rf_raddr2);
    end

    assign res_valid = mewb.valid;
    assign res_rd    = mewb.rd;
    assign res_data  = mewb.data;
    assign res_fl    = mewb.fl;
    assign res_lr    = mewb.lr;

endmodule

// File: design/alu_pipe_top.sv
`timescale 1ns/1ps

module alu_pipe_top #(
    parameter int data_w = 32
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    input  isa_pkg::opcode_e          instr_op,
    input  pipe_pkg::reg_idx_t        instr_rd,
    input  pipe_pkg::reg_idx_t        instr_rs1,
    input  pipe_pkg::reg_idx_t        instr_rs2,
    input  logic [isa_pkg::imm_w-1:0] instr_imm,
    output logic                      res_valid,
    input  logic                      res_ready,
    output pipe_pkg::reg_idx_t        res_rd,
    output logic [data_w-1:0]         res_data,
    output isa_pkg::fl_t              res_fl,
    output logic [data_w-1:0]         res_lr
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic              advance;
    reg_idx_t          rf_raddr1;
    reg_idx_t          rf_raddr2;
    logic [data_w-1:0] rf_rdata1;
    logic [data_w-1:0] rf_rdata2;
    fl_t               arch_fl;
    logic [data_w-1:0] arch_lr;

    issue_if  #(.data_w(data_w)) de_ex ();
    result_if #(.data_w(data_w)) exme_bus ();
    result_if #(.data_w(data_w)) mewb_bus ();

    decode_stage #(.data_w(data_w)) u_decode (
        .clk, .arst_n, .advance,
        .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2, .instr_imm,
        .instr_ready,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .de_ex    (de_ex)
    );

    execute_stage #(.data_w(data_w)) u_execute (
        .clk, .arst_n, .advance,
        .de_ex    (de_ex),
        .mewb     (mewb_bus),
        .arch_fl, .arch_lr,
        .exme     (exme_bus)
    );

    // commit owns the architectural state and the result port
    commit_stage #(.data_w(data_w)) u_commit (
        .clk, .arst_n,
        .exme     (exme_bus),
        .mewb     (mewb_bus),
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .arch_fl, .arch_lr, .advance,
        .res_valid, .res_ready, .res_rd, .res_data, .res_fl, .res_lr
    );

endmodule

// File: sim/alu_pipe_props.sv
`timescale 1ns/1ps

module alu_pipe_props #(
    parameter int data_w = 32
) (
    input logic               clk,
    input logic               arst_n,
    input logic               instr_ready,
    input logic               res_valid,
    input logic               res_ready,
    input pipe_pkg::reg_idx_t res_rd,
    input logic [data_w-1:0]  res_data,
    input isa_pkg::fl_t       res_fl,
    input logic [data_w-1:0]  res_lr
);

    // a result that is not taken keeps its whole payload
    assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_rd) && $stable(res_data)
            && $stable(res_fl) && $stable(res_lr))
        else $error("result payload changed while stalled");

    assert property (@(posedge clk) !arst_n |-> !res_valid)
        else $error("res_valid high during reset");

    // back-pressure from the result port freezes the whole pipe
    assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |-> !instr_ready)
        else $error("instr_ready high while the result port is stalled");

endmodule

bind alu_pipe_top alu_pipe_props #(.data_w(data_w)) u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_ready (instr_ready),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_fl      (res_fl),
    .res_lr      (res_lr)
);

// File: sim/alu_pipe_tb.sv
`timescale 1ns/1ps

module alu_pipe_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int data_w   = 32;
    localparam int max_wait = 200;

    typedef struct packed {
        opcode_e          op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [imm_w-1:0] imm;
    } instr_t;

    typedef struct packed {
        reg_idx_t          rd;
        logic [data_w-1:0] data;
        logic [1:0]        fl;
        logic [data_w-1:0] lr;
    } expect_t;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              instr_valid;
    logic              instr_ready;
    opcode_e           instr_op;
    reg_idx_t          instr_rd;
    reg_idx_t          instr_rs1;
    reg_idx_t          instr_rs2;
    logic [imm_w-1:0]  instr_imm;
    logic              res_valid;
    logic              res_ready;
    reg_idx_t          res_rd;
    logic [data_w-1:0] res_data;
    fl_t               res_fl;
    logic [data_w-1:0] res_lr;

    // architectural model, {neg, zero} for FL
    logic [data_w-1:0] m_regs [32];
    logic [1:0]        m_fl;
    logic [data_w-1:0] m_lr;
    expect_t           exp_q [$];
    instr_t            todo_q [$];

    alu_pipe_top #(.data_w(data_w)) dut (
        .clk, .arst_n,
        .instr_valid, .instr_ready, .instr_op, .instr_rd, .instr_rs1, .instr_rs2, .instr_imm,
        .res_valid, .res_ready, .res_rd, .res_data, .res_fl, .res_lr
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic push_instr(input opcode_e op, input int rd, input int rs1,
                              input int rs2, input int imm);
        instr_t i;
        i.op  = op;
        i.rd  = reg_idx_t'(rd);
        i.rs1 = reg_idx_t'(rs1);
        i.rs2 = reg_idx_t'(rs2);
        i.imm = imm_w'(imm);
        todo_q.push_back(i);
    endtask

    // directed sequences first, random ones with registers 0 to 7 otherwise
    task automatic next_instr();
        instr_t i;
        if (todo_q.size() != 0) begin
            i = todo_q.pop_front();
        end else begin
            case ($urandom % 15)
                0:       i.op = OP_ADD;
                1:       i.op = OP_SUB;
                2:       i.op = OP_AND;
                3:       i.op = OP_OR;
                4:       i.op = OP_XOR;
                5:       i.op = OP_MOVI;
                6, 7:    i.op = OP_CMP;
                8, 9:    i.op = OP_SETLR;
                10, 11:  i.op = OP_GETLR;
                default: i.op = OP_GETFL;
            endcase
            i.rd  = reg_idx_t'($urandom % 8);
            i.rs1 = reg_idx_t'($urandom % 8);
            i.rs2 = reg_idx_t'($urandom % 8);
            i.imm = imm_w'($urandom);
        end
        instr_op  = i.op;
        instr_rd  = i.rd;
        instr_rs1 = i.rs1;
        instr_rs2 = i.rs2;
        instr_imm = i.imm;
    endtask

    // executes the accepted instruction in program order
    task automatic model_accept();
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] val;
        expect_t           e;
        a = (instr_rs1 == 0) ? '0 : m_regs[instr_rs1];
        b = (instr_rs2 == 0) ? '0 : m_regs[instr_rs2];
        case (instr_op)
            OP_ADD:         val = a + b;
            OP_SUB, OP_CMP: val = a - b;
            OP_AND:         val = a & b;
            OP_OR:          val = a | b;
            OP_XOR:         val = a ^ b;
            OP_MOVI:        val = data_w'(instr_imm);
            OP_SETLR:       val = a;
            OP_GETLR:       val = m_lr;
            OP_GETFL:       val = data_w'(m_fl);
            default:        val = '0;
        endcase
        if (instr_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP}) begin
            m_fl = {val[data_w-1], val == '0};
        end
        if (instr_op == OP_SETLR) begin
            m_lr = a;
        end
        if (!(instr_op inside {OP_CMP, OP_SETLR}) && instr_rd != 0) begin
            m_regs[instr_rd] = val;
        end
        e.rd   = instr_rd;
        e.data = val;
        e.fl   = m_fl;
        e.lr   = m_lr;
        exp_q.push_back(e);
    endtask

    task automatic check_result();
        expect_t e;
        if (exp_q.size() == 0) begin
            abort_run("a result was delivered with no instruction outstanding");
        end else begin
            e = exp_q.pop_front();
            check_value("res_rd", data_w'(res_rd), data_w'(e.rd));
            check_value("res_data", res_data, e.data);
            check_value("res_fl", data_w'(res_fl), data_w'(e.fl));
            check_value("res_lr", res_lr, e.lr);
        end
    endtask

    // sends count instructions and runs until every result is back
    task automatic run_stream(input int count, input int valid_pct, input int ready_pct);
        int accepted;
        int issued;
        int idle;
        bit hold;
        bit progress;
        accepted = 0;
        issued   = 0;
        idle     = 0;
        hold     = 1'b0;
        while (accepted < count || exp_q.size() != 0) begin
            @(negedge clk);
            if (!hold) begin
                instr_valid = 1'b0;
                if (issued < count && ($urandom % 100) < valid_pct) begin
                    next_instr();
                    instr_valid = 1'b1;
                    hold        = 1'b1;
                    issued++;
                end
            end
            res_ready = ($urandom % 100) < ready_pct;
            #1;
            progress = 1'b0;
            if (instr_valid && instr_ready) begin
                model_accept();
                hold     = 1'b0;
                progress = 1'b1;
                accepted++;
            end
            if (res_valid && res_ready) begin
                check_result();
                progress = 1'b1;
            end
            idle = progress ? 0 : idle + 1;
            if (idle > max_wait) begin
                abort_run("timeout: no transfer on either port within the wait limit");
            end
        end
    endtask

    // a lone instruction retires three edges after it is accepted
    task automatic check_latency();
        int cycles;
        @(negedge clk);
        push_instr(OP_MOVI, 3, 0, 0, 'h1234);
        next_instr();
        instr_valid = 1'b1;
        res_ready   = 1'b1;
        #1;
        check_value("instr_ready on empty pipe", data_w'(instr_ready), data_w'(1));
        model_accept();
        cycles = 0;
        while (!(res_valid && res_ready)) begin
            @(negedge clk);
            instr_valid = 1'b0;
            cycles++;
            #1;
            if (cycles > max_wait) begin
                abort_run("timeout waiting for the result of a lone instruction");
            end
        end
        check_result();
        check_value("result latency in cycles", data_w'(cycles), data_w'(3));
    endtask

    task automatic queue_directed();
        push_instr(OP_MOVI, 1, 0, 0, 5);
        push_instr(OP_MOVI, 2, 0, 0, 7);
        // r2 at distance 1, r1 at distance 2
        push_instr(OP_SUB, 3, 1, 2, 0);
        push_instr(OP_GETFL, 4, 0, 0, 0);
        push_instr(OP_ADD, 5, 3, 1, 0);
        // r3 at distance 3 comes through the write-first read
        push_instr(OP_XOR, 6, 3, 0, 0);
        push_instr(OP_CMP, 0, 1, 1, 0);
        push_instr(OP_MOVI, 7, 0, 0, 'h8000);
        push_instr(OP_GETFL, 7, 0, 0, 0);
        push_instr(OP_SETLR, 0, 3, 0, 0);
        push_instr(OP_GETLR, 1, 0, 0, 0);
        push_instr(OP_MOVI, 0, 0, 0, 'hbeef);
        push_instr(OP_OR, 2, 0, 0, 0);
    endtask

    initial begin
        void'($urandom(32'hffe0));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr_op    = OP_ADD;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_imm   = '0;
        res_ready   = 1'b0;
        m_fl        = '0;
        m_lr        = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_value("res_valid after reset", data_w'(res_valid), '0);
        check_value("instr_ready after reset", data_w'(instr_ready), data_w'(1));
        check_latency();
        queue_directed();
        run_stream(todo_q.size(), 100, 100);
        // back-to-back random stream, then random handshakes on both ports
        run_stream(150, 100, 100);
        run_stream(250, 70, 60);
        repeat (5) begin
            @(negedge clk);
            res_ready = 1'b1;
            #1;
            check_value("res_valid on a drained pipe", data_w'(res_valid), '0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// File: vlog.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/stage_if.sv
design/decode_stage.sv
design/forwarding.sv
design/execute_stage.sv
design/commit_stage.sv
design/alu_pipe_top.sv
sim/alu_pipe_props.sv
sim/alu_pipe_tb.sv

// File: Makefile
# Verilator build and run of the pipelined ALU testbench

TOP := alu_pipe_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
